// ==== flist.f ====
+incdir+design
design/cluster_pkg.sv
design/cluster_core.sv
design/mem_arb.sv
design/cluster.sv
verification/mem_model.sv
verification/cluster_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the cluster testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cluster_tb -f flist.f \
    --Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vcluster_tb > sim.log 2>&1 \
    || echo "build or simulation stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0

// ==== verification/cluster_tb.sv ====
`timescale 1ns/100ps
`include "cluster_defines.svh"

module cluster_tb;

    localparam int          N          = `NUM_CORES;
    localparam int          SEL        = `CORE_SEL_WIDTH;
    localparam int          TOTAL_CMDS = 20 + 32 + 16 + 200;
    localparam int          LIMIT      = 64 * TOTAL_CMDS + 16;
    localparam logic [31:0] SEED       = 32'd51;

    logic                               clk;
    logic                               arst_n;
    logic [N-1:0]                       cmd_valid;
    cluster_pkg::mem_op_e [N-1:0]       cmd_op;
    logic [N-1:0][`ADDR_WIDTH-1:0]      cmd_addr;
    logic [N-1:0][`DATA_WIDTH-1:0]      cmd_data;
    logic [N-1:0]                       cmd_ready;
    logic [N-1:0]                       done;
    logic [N-1:0]                       pend;
    logic [N-1:0]                       pend_q;
    logic [N-1:0][`DATA_WIDTH-1:0]      done_data;
    logic                               mem_req_valid;
    logic                               mem_req_rw;
    logic                               mem_req_ready;
    logic [`ADDR_WIDTH-1:0]             mem_req_addr;
    logic [`DATA_WIDTH-1:0]             mem_req_data;
    logic [`DATA_WIDTH-1:0]             mem_rsp_data;
    logic [`MEM_TAG_WIDTH-1:0]          mem_req_tag;
    logic [`MEM_TAG_WIDTH-1:0]          mem_rsp_tag;
    logic                               mem_rsp_valid;
    logic                               busy;
    logic [31:0]                        mem_rnd = SEED ^ 32'h9e37_79b9;
    logic [31:0]                        seeds [N+1];    // one stream per core plus one shared
    logic [`DATA_WIDTH-1:0]             ref_mem [1 << `ADDR_WIDTH];
    logic [`DATA_WIDTH-1:0]             exp_data [N];
    string                              test_name;
    int                                 err_count;
    int                                 issued;
    int                                 completed;
    int                                 tests;
    int                                 cycles;
    int                                 err0;
    int                                 issued0;
    int                                 done0;

    cluster dut_i (.*);
    mem_model mem_i (.rnd(mem_rnd), .*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] draw(input int k);
        seeds[k] = xorshift(seeds[k]);
        return seeds[k];
    endfunction

    // Low address bits name the core so cores stay on disjoint words
    function automatic logic [`ADDR_WIDTH-1:0] core_addr(input int c, input logic [31:0] r);
        logic [`ADDR_WIDTH-1:0] a;
        a = r[`ADDR_WIDTH-1:0];
        a[SEL-1:0] = c[SEL-1:0];
        return a;
    endfunction

    task automatic issue(input int c, input cluster_pkg::mem_op_e op,
                         input logic [`ADDR_WIDTH-1:0] addr, input logic [`DATA_WIDTH-1:0] data);
        @(negedge clk);
        cmd_valid[c] = 1'b1;
        cmd_op[c]    = op;
        cmd_addr[c]  = addr;
        cmd_data[c]  = data;
        while (!cmd_ready[c]) @(negedge clk);
        case (op)   // transfer on the coming rising edge
            cluster_pkg::OP_LOAD: exp_data[c] = ref_mem[addr];
            cluster_pkg::OP_STORE: begin
                exp_data[c]   = data;
                ref_mem[addr] = data;
            end
            default: begin
                exp_data[c]   = ref_mem[addr];
                ref_mem[addr] = ref_mem[addr] + data;   // wraps at word width
            end
        endcase
        pend[c] = 1'b1;
        issued++;
        @(negedge clk);
        cmd_valid[c] = 1'b0;
    endtask

    task automatic wait_quiet();
        while (pend_q != '0) @(negedge clk);
    endtask

    task automatic run_one(input int c, input cluster_pkg::mem_op_e op,
                           input logic [`ADDR_WIDTH-1:0] addr, input logic [`DATA_WIDTH-1:0] data);
        issue(c, op, addr, data);
        wait_quiet();
    endtask

    task automatic mixed_stream(input int k, input int n);
        logic [31:0] r;
        repeat (n) begin
            r = draw(k);
            repeat (r[3:2]) @(negedge clk);
            issue(k, cluster_pkg::mem_op_e'(r[31:8] % 3), core_addr(k, r >> 12), r[31:16]);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err0      = err_count;
        issued0   = issued;
        done0     = completed;
    endtask

    task automatic finish_test(input int cmds);
        if (issued - issued0 != cmds || completed - done0 != cmds) begin
            $display("%s: %0d commands issued and %0d completed, %0d expected",
                     test_name, issued - issued0, completed - done0, cmds);
            err_count++;
        end
        $display("%s: %0d commands, %0d errors", test_name, completed - done0, err_count - err0);
        tests++;
    endtask

    always @(posedge clk) begin
        pend_q  <= pend;
        mem_rnd <= xorshift(mem_rnd);
    end

    // Completion, busy and tag monitor
    always @(negedge clk) begin
        if (!arst_n) begin
            if ({done, mem_req_valid, busy} !== {(N + 2){1'b0}}) begin
                $display("mismatch %s done, mem_req_valid, busy: expected %b, actual %b",
                         test_name, {(N + 2){1'b0}}, {done, mem_req_valid, busy});
                err_count++;
            end
        end else begin
            if (busy !== |pend_q) begin
                $display("mismatch %s busy: expected %b, actual %b", test_name, |pend_q, busy);
                err_count++;
            end
            if (mem_req_valid && mem_req_tag !== mem_req_addr[SEL-1:0]) begin
                $display("mismatch %s mem_req_tag: expected %0d, actual %0d",
                         test_name, mem_req_addr[SEL-1:0], mem_req_tag);
                err_count++;
            end
            for (int c = 0; c < N; c++) begin
                if (done[c]) begin
                    if (!pend[c]) begin
                        $display("%s: core %0d gave done without an accepted command",
                                 test_name, c);
                        err_count++;
                    end else if (done_data[c] !== exp_data[c]) begin
                        $display("mismatch %s core %0d: expected %h, actual %h",
                                 test_name, c, exp_data[c], done_data[c]);
                        err_count++;
                    end
                    pend[c] = 1'b0;
                    completed++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("run timed out after %0d cycles", cycles);
            err_count++;
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int c;
        logic [31:0] r;
        arst_n    = 1'b0;
        cmd_valid = '0;
        cmd_addr  = '0;
        cmd_data  = '0;
        pend      = '0;
        for (int k = 0; k < N; k++) cmd_op[k] = cluster_pkg::OP_LOAD;
        for (int k = 0; k <= N; k++) seeds[k] = xorshift(SEED + k);
        for (int a = 0; a < (1 << `ADDR_WIDTH); a++) begin
            r = draw(N);
            ref_mem[a]   = r[`DATA_WIDTH-1:0] ^ `DATA_WIDTH'(a);
            mem_i.mem[a] = ref_mem[a];
        end

        start_test("reset");
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        if (cmd_ready !== {N{1'b1}}) begin
            $display("mismatch %s cmd_ready: expected %b, actual %b",
                     test_name, {N{1'b1}}, cmd_ready);
            err_count++;
        end
        if (mem_req_valid !== 1'b0) begin
            $display("mismatch %s mem_req_valid: expected %b, actual %b",
                     test_name, 1'b0, mem_req_valid);
            err_count++;
        end
        finish_test(0);

        start_test("loads");
        repeat (20) begin
            r = draw(N);
            c = r[7:0] % N;
            run_one(c, cluster_pkg::OP_LOAD, core_addr(c, r >> 8), '0);
        end
        finish_test(20);

        start_test("store_load");
        repeat (16) begin
            r = draw(N);
            c = r[7:0] % N;
            run_one(c, cluster_pkg::OP_STORE, core_addr(c, r >> 8), r[31:16]);
            run_one(c, cluster_pkg::OP_LOAD, core_addr(c, r >> 8), '0);
        end
        finish_test(32);

        start_test("fetch_add");
        repeat (8) begin
            r = draw(N);
            c = r[7:0] % N;
            run_one(c, cluster_pkg::OP_ADD, core_addr(c, r >> 8), r[31:16]);
            run_one(c, cluster_pkg::OP_LOAD, core_addr(c, r >> 8), '0);
        end
        finish_test(16);

        start_test("mixed");
        for (int k = 0; k < N; k++) begin
            fork
                automatic int kk = k;
                mixed_stream(kk, 200 / N);
            join_none
        end
        wait fork;
        wait_quiet();
        finish_test(200);

        start_test("busy_idle");
        @(negedge clk);
        if (busy !== 1'b0) begin
            $display("mismatch %s busy: expected %b, actual %b", test_name, 1'b0, busy);
            err_count++;
        end
        finish_test(0);

        $display("tests %0d, commands %0d, errors %0d", tests, completed, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verification/mem_model.sv ====
`timescale 1ns/100ps
`include "cluster_defines.svh"

module mem_model (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic [31:0]                             rnd,
    input  logic                                    mem_req_valid,
    input  logic                                    mem_req_rw,
    input  logic [`ADDR_WIDTH-1:0]                  mem_req_addr,
    input  logic [`DATA_WIDTH-1:0]                  mem_req_data,
    input  logic [`MEM_TAG_WIDTH-1:0]               mem_req_tag,
    output logic                                    mem_req_ready,
    output logic                                    mem_rsp_valid,
    output logic [`DATA_WIDTH-1:0]                  mem_rsp_data,
    output logic [`MEM_TAG_WIDTH-1:0]               mem_rsp_tag
);

    logic [`DATA_WIDTH-1:0]                         mem [1 << `ADDR_WIDTH];
    int                                             cycle = 0;
    int                                             last_due = 0;
    int                                             due_q [$];
    logic [`MEM_TAG_WIDTH+`DATA_WIDTH-1:0]          rsp_q [$];  // {tag, data}

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        mem_rsp_tag   = '0;
    end

    // Outputs move on the falling edge, requests are seen where stable
    always @(negedge clk) begin
        int due;
        cycle++;
        mem_rsp_valid = 1'b0;
        if (!arst_n) begin
            mem_req_ready = 1'b0;
            last_due      = cycle;
            due_q.delete();
            rsp_q.delete();
        end else begin
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                {mem_rsp_tag, mem_rsp_data} = rsp_q.pop_front();
                mem_rsp_valid = 1'b1;
            end
            mem_req_ready = (rnd[1:0] != 2'b00);
            if (mem_req_valid && mem_req_ready) begin   // transfer on the next rising edge
                if (mem_req_rw) begin
                    mem[mem_req_addr] = mem_req_data;
                end else begin
                    due = cycle + 1 + (int'(rnd[10:8]) % 6);
                    if (due <= last_due) due = last_due + 1;  // keep reads in order
                    last_due = due;
                    due_q.push_back(due);
                    rsp_q.push_back({mem_req_tag, mem[mem_req_addr]});
                end
            end
        end
    end

endmodule

// ==== design/cluster.sv ====
`timescale 1ns/100ps
`include "cluster_defines.svh"

module cluster (
    input  logic                                        clk,
    input  logic                                        arst_n,

    // Commands, one per core
    input  logic [`NUM_CORES-1:0]                       cmd_valid,
    input  cluster_pkg::mem_op_e [`NUM_CORES-1:0]       cmd_op,
    input  logic [`NUM_CORES-1:0][`ADDR_WIDTH-1:0]      cmd_addr,
    input  logic [`NUM_CORES-1:0][`DATA_WIDTH-1:0]      cmd_data,
    output logic [`NUM_CORES-1:0]                       cmd_ready,

    // Completion
    output logic [`NUM_CORES-1:0]                       done,
    output logic [`NUM_CORES-1:0][`DATA_WIDTH-1:0]      done_data,

    // Memory request
    output logic                                        mem_req_valid,
    output logic                                        mem_req_rw,
    output logic [`ADDR_WIDTH-1:0]                      mem_req_addr,
    output logic [`DATA_WIDTH-1:0]                      mem_req_data,
    output logic [`MEM_TAG_WIDTH-1:0]                   mem_req_tag,
    input  logic                                        mem_req_ready,

    // Memory response
    input  logic                                        mem_rsp_valid,
    input  logic [`DATA_WIDTH-1:0]                      mem_rsp_data,
    input  logic [`MEM_TAG_WIDTH-1:0]                   mem_rsp_tag,

    output logic                                        busy
);

    logic [`NUM_CORES-1:0]                      core_req_valid;
    logic [`NUM_CORES-1:0]                      core_req_rw;
    logic [`NUM_CORES-1:0][`ADDR_WIDTH-1:0]     core_req_addr;
    logic [`NUM_CORES-1:0][`DATA_WIDTH-1:0]     core_req_data;
    logic [`NUM_CORES-1:0]                      core_req_ready;
    logic [`NUM_CORES-1:0]                      core_rsp_valid;
    logic [`NUM_CORES-1:0][`DATA_WIDTH-1:0]     core_rsp_data;
    logic [`NUM_CORES-1:0]                      core_busy;

    for (genvar i = 0; i < `NUM_CORES; i++) begin : g_core
        cluster_core core_i (
            .clk        (clk),
            .arst_n     (arst_n),
            .cmd_valid  (cmd_valid[i]),
            .cmd_op     (cmd_op[i]),
            .cmd_addr   (cmd_addr[i]),
            .cmd_data   (cmd_data[i]),
            .cmd_ready  (cmd_ready[i]),
            .req_valid  (core_req_valid[i]),
            .req_rw     (core_req_rw[i]),
            .req_addr   (core_req_addr[i]),
            .req_data   (core_req_data[i]),
            .req_ready  (core_req_ready[i]),
            .rsp_valid  (core_rsp_valid[i]),
            .rsp_data   (core_rsp_data[i]),
            .done       (done[i]),
            .done_data  (done_data[i]),
            .busy       (core_busy[i])
        );
    end

    assign busy = |core_busy;   // any core mid-command

    mem_arb mem_arb_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (core_req_valid),
        .req_rw         (core_req_rw),
        .req_addr       (core_req_addr),
        .req_data       (core_req_data),
        .req_ready      (core_req_ready),
        .rsp_valid      (core_rsp_valid),
        .rsp_data       (core_rsp_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_tag    (mem_req_tag),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_tag    (mem_rsp_tag)
    );

endmodule

// ==== design/mem_arb.sv ====
`timescale 1ns/100ps
`include "cluster_defines.svh"

module mem_arb (
    input  logic                                        clk,
    input  logic                                        arst_n,

    // Core requests
    input  logic [`NUM_CORES-1:0]                       req_valid,
    input  logic [`NUM_CORES-1:0]                       req_rw,
    input  logic [`NUM_CORES-1:0][`ADDR_WIDTH-1:0]      req_addr,
    input  logic [`NUM_CORES-1:0][`DATA_WIDTH-1:0]      req_data,
    output logic [`NUM_CORES-1:0]                       req_ready,

    // Core responses
    output logic [`NUM_CORES-1:0]                       rsp_valid,
    output logic [`NUM_CORES-1:0][`DATA_WIDTH-1:0]      rsp_data,

    // Memory request
    output logic                                        mem_req_valid,
    output logic                                        mem_req_rw,
    output logic [`ADDR_WIDTH-1:0]                      mem_req_addr,
    output logic [`DATA_WIDTH-1:0]                      mem_req_data,
    output logic [`MEM_TAG_WIDTH-1:0]                   mem_req_tag,
    input  logic                                        mem_req_ready,

    // Memory response
    input  logic                                        mem_rsp_valid,
    input  logic [`DATA_WIDTH-1:0]                      mem_rsp_data,
    input  logic [`MEM_TAG_WIDTH-1:0]                   mem_rsp_tag
);

    logic [`CORE_SEL_WIDTH-1:0]     rr_ptr;     // highest priority core
    logic [`CORE_SEL_WIDTH-1:0]     cand_idx;
    logic [`CORE_SEL_WIDTH-1:0]     grant_idx;
    logic                           found;
    logic                           can_accept;
    logic [`NUM_CORES-1:0]          grant;

    logic                           out_valid_q;
    logic                           out_rw_q;
    logic [`ADDR_WIDTH-1:0]         out_addr_q;
    logic [`DATA_WIDTH-1:0]         out_data_q;
    logic [`MEM_TAG_WIDTH-1:0]      out_tag_q;

    logic [`NUM_CORES-1:0]          rsp_valid_q;
    logic [`DATA_WIDTH-1:0]         rsp_data_q;

    // Output stage empty or draining this cycle
    assign can_accept = !out_valid_q || mem_req_ready;

    always_comb begin
        found     = 1'b0;
        grant_idx = '0;
        cand_idx  = '0;
        grant     = '0;
        for (int i = 0; i < `NUM_CORES; i++) begin
            cand_idx = rr_ptr + `CORE_SEL_WIDTH'(i);  // wraps around the cores
            if (!found && req_valid[cand_idx]) begin
                found     = 1'b1;
                grant_idx = cand_idx;
            end
        end
        if (found && can_accept) begin
            grant[grant_idx] = 1'b1;
        end
    end

    assign req_ready = grant;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q <= 1'b0;
            rr_ptr      <= '0;
        end else if (|grant) begin
            out_valid_q <= 1'b1;
            rr_ptr      <= grant_idx + 1'b1;
        end else if (mem_req_ready) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            out_rw_q   <= req_rw[grant_idx];
            out_addr_q <= req_addr[grant_idx];
            out_data_q <= req_data[grant_idx];
            out_tag_q  <= grant_idx;
        end
    end

    assign mem_req_valid = out_valid_q;
    assign mem_req_rw    = out_rw_q;
    assign mem_req_addr  = out_addr_q;
    assign mem_req_data  = out_data_q;
    assign mem_req_tag   = out_tag_q;

    // Response routing by tag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid_q <= '0;
        end else begin
            for (int i = 0; i < `NUM_CORES; i++) begin
                rsp_valid_q[i] <= mem_rsp_valid && (mem_rsp_tag == `MEM_TAG_WIDTH'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rsp_valid) rsp_data_q <= mem_rsp_data;
    end

    assign rsp_valid = rsp_valid_q;

    always_comb begin
        for (int i = 0; i < `NUM_CORES; i++) begin
            rsp_data[i] = rsp_data_q;   // only the tagged core sees valid
        end
    end

    // No requesting core is skipped while the output stage has room
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(grant) && ((|grant) == ((|req_valid) && can_accept))
    );

    a_mem_req_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_req_valid && !mem_req_ready) |=>
            mem_req_valid && $stable({mem_req_rw, mem_req_addr, mem_req_data, mem_req_tag})
    );

endmodule

// ==== design/cluster_core.sv ====
`timescale 1ns/100ps
`include "cluster_defines.svh"

module cluster_core (
    input  logic                        clk,
    input  logic                        arst_n,

    // Command
    input  logic                        cmd_valid,
    input  cluster_pkg::mem_op_e        cmd_op,
    input  logic [`ADDR_WIDTH-1:0]      cmd_addr,
    input  logic [`DATA_WIDTH-1:0]      cmd_data,
    output logic                        cmd_ready,

    // Memory request
    output logic                        req_valid,
    output logic                        req_rw,
    output logic [`ADDR_WIDTH-1:0]      req_addr,
    output logic [`DATA_WIDTH-1:0]      req_data,
    input  logic                        req_ready,

    // Memory response
    input  logic                        rsp_valid,
    input  logic [`DATA_WIDTH-1:0]      rsp_data,

    // Completion
    output logic                        done,
    output logic [`DATA_WIDTH-1:0]      done_data,
    output logic                        busy
);

    cluster_pkg::core_state_e   state;
    cluster_pkg::core_state_e   state_d;
    cluster_pkg::mem_op_e       op_q;
    logic [`ADDR_WIDTH-1:0]     addr_q;
    logic [`DATA_WIDTH-1:0]     wdata_q;    // store word or add operand
    logic [`DATA_WIDTH-1:0]     result_q;
    logic                       cmd_fire;
    logic                       req_fire;

    assign cmd_fire = cmd_valid && cmd_ready;
    assign req_fire = req_valid && req_ready;

    always_comb begin
        state_d = state;
        case (state)
            cluster_pkg::ST_IDLE: begin
                if (cmd_fire) begin
                    state_d = (cmd_op == cluster_pkg::OP_STORE) ? cluster_pkg::ST_WRITE
                                                                : cluster_pkg::ST_READ;
                end
            end
            cluster_pkg::ST_READ: begin
                if (req_fire) state_d = cluster_pkg::ST_WAIT;
            end
            cluster_pkg::ST_WAIT: begin
                if (rsp_valid) begin
                    // Add goes on to write back the sum
                    state_d = (op_q == cluster_pkg::OP_ADD) ? cluster_pkg::ST_WRITE
                                                            : cluster_pkg::ST_DONE;
                end
            end
            cluster_pkg::ST_WRITE: begin
                if (req_fire) state_d = cluster_pkg::ST_DONE;
            end
            cluster_pkg::ST_DONE: state_d = cluster_pkg::ST_IDLE;
            default: state_d = cluster_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cluster_pkg::ST_IDLE;
        end else begin
            state <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            op_q     <= cmd_op;
            addr_q   <= cmd_addr;
            wdata_q  <= cmd_data;
            result_q <= cmd_data;  // store reports its own word
        end
        if (rsp_valid) begin
            result_q <= rsp_data;             // old word
            wdata_q  <= rsp_data + wdata_q;   // wraps at DATA_WIDTH
        end
    end

    assign cmd_ready = (state == cluster_pkg::ST_IDLE);
    assign req_valid = (state == cluster_pkg::ST_READ) || (state == cluster_pkg::ST_WRITE);
    assign req_rw    = (state == cluster_pkg::ST_WRITE);
    assign req_addr  = addr_q;
    assign req_data  = wdata_q;
    assign done      = (state == cluster_pkg::ST_DONE);
    assign done_data = result_q;
    assign busy      = (state != cluster_pkg::ST_IDLE);

    // Arbiter must only route our own reads back
    a_rsp_in_wait: assert property (
        @(posedge clk) disable iff (!arst_n)
        rsp_valid |-> (state == cluster_pkg::ST_WAIT)
    );

    a_req_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (req_valid && !req_ready) |=> req_valid && $stable({req_rw, req_addr, req_data})
    );

endmodule

// ==== design/cluster_pkg.sv ====
package cluster_pkg;

    // Command operation
    typedef enum logic [1:0] {
        OP_LOAD,
        OP_STORE,
        OP_ADD      // fetch-and-add, returns old word
    } mem_op_e;

    // Per-core sequencer state
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT,
        ST_WRITE,
        ST_DONE
    } core_state_e;

endpackage

// ==== design/cluster_defines.svh ====
`ifndef CLUSTER_DEFINES_SVH
`define CLUSTER_DEFINES_SVH

// Cluster size, 2, 4 or 8 cores
`define NUM_CORES       4
`define CORE_SEL_WIDTH  2

// Word addressed memory
`define ADDR_WIDTH      8
`define DATA_WIDTH      16

// Tag carries the issuing core index
`define MEM_TAG_WIDTH   `CORE_SEL_WIDTH

`endif
